// File: vlog.f
src/hb_mc_pkg.sv
src/mcl_axil_fifos.sv
src/mc_endpoint.sv
src/mem_arbiter.sv
src/dram_bank.sv
src/hb_mc_top.sv
tb/hb_mc_assert.sv
tb/tb_hb_mc.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_hb_mc \
  -o sim_tb_hb_mc > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb_hb_mc +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: tb/tb_hb_mc.sv
// --------------------
// testbench for the host bridge
// AXI-lite and DMA stimulus, memory reference model
// checks, timeout and summary
// --------------------
`timescale 1ns/1ps

module tb_hb_mc import hb_mc_pkg::*; ();

  localparam int addr_w_lp   = 10;
  localparam int depth_lp    = 4;
  localparam int credits_lp  = 4;
  localparam int rand_ops_lp = 12;
  // about 60 fixed transactions plus 10 per random round
  localparam int timeout_lp  = 40 * (60 + 10 * rand_ops_lp);

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic [31:0]          awaddr, wdata, araddr, rdata;
  logic [3:0]           wstrb;
  logic                 awvalid, wvalid, bready, arvalid, rready;
  logic                 awready, wready, bvalid, arready, rvalid;
  logic [1:0]           bresp, rresp;
  logic                 dma_v, dma_we, dma_ready, dma_rvalid;
  logic [addr_w_lp-1:0] dma_addr;
  logic [31:0]          dma_wdata, dma_rdata;

  logic [31:0]          ref_mem [int];
  logic [31:0]          dma_exp_q [$];
  logic                 dma_rd_pend = 1'b0;
  logic [15:0]          h_addr [rand_ops_lp];
  logic [31:0]          h_data [rand_ops_lp];
  int                   h_pick [rand_ops_lp];
  logic [addr_w_lp-1:0] d_addr [rand_ops_lp];
  logic [31:0]          d_data [rand_ops_lp];
  int                   d_pick [rand_ops_lp];
  int                   seed = 20;
  int                   cycles = 0;
  int                   n_checks = 0;
  int                   n_errors = 0;
  int                   n_tests = 0;

  always #2 clk = ~clk;

  hb_mc_top #(
    .mem_addr_width_p (addr_w_lp),
    .fifo_depth_p     (depth_lp),
    .max_out_credits_p(credits_lp)
  ) u_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .s_axil_awaddr_i (awaddr),
    .s_axil_awvalid_i(awvalid),
    .s_axil_awready_o(awready),
    .s_axil_wdata_i  (wdata),
    .s_axil_wstrb_i  (wstrb),
    .s_axil_wvalid_i (wvalid),
    .s_axil_wready_o (wready),
    .s_axil_bresp_o  (bresp),
    .s_axil_bvalid_o (bvalid),
    .s_axil_bready_i (bready),
    .s_axil_araddr_i (araddr),
    .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready),
    .s_axil_rdata_o  (rdata),
    .s_axil_rresp_o  (rresp),
    .s_axil_rvalid_o (rvalid),
    .s_axil_rready_i (rready),
    .dma_v_i         (dma_v),
    .dma_we_i        (dma_we),
    .dma_addr_i      (dma_addr),
    .dma_wdata_i     (dma_wdata),
    .dma_ready_o     (dma_ready),
    .dma_rdata_o     (dma_rdata),
    .dma_rvalid_o    (dma_rvalid)
  );

  // --------------------
  // reference model
  // --------------------
  function automatic void ref_store(input int addr, input logic [31:0] data);
    ref_mem[addr] = data;
  endfunction

  function automatic logic [31:0] ref_load(input int addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : 32'hx;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    awaddr  = {20'h0, addr};
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge clk); while (!awready);
    check_val("wready with awready", {31'h0, wready}, 1);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    araddr  = {20'h0, addr};
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    #1;
    rready = 1'b0;
  endtask

  task automatic dma_access(input logic we, input logic [addr_w_lp-1:0] addr,
                            input logic [31:0] data);
    dma_v     = 1'b1;
    dma_we    = we;
    dma_addr  = addr;
    dma_wdata = data;
    do @(posedge clk); while (!dma_ready);
    if (we) begin
      ref_store(addr, data);
    end else begin
      dma_exp_q.push_back(ref_load(addr));
    end
    #1;
    dma_v = 1'b0;
  endtask

  task automatic send_packet(input mc_op_e op, input logic [15:0] addr, input logic [31:0] lo);
    logic [1:0] r;
    axil_write(axil_tx_lo_c, lo, r);
    check_val("tx_lo bresp", {30'h0, r}, {30'h0, resp_okay_c});
    axil_write(axil_tx_hi_c, {op, 14'h0, addr}, r);
    check_val("tx_hi bresp", {30'h0, r}, {30'h0, resp_okay_c});
  endtask

  task automatic host_store(input logic [15:0] addr, input logic [31:0] data);
    send_packet(op_store, addr, data);
    ref_store(addr, data);
  endtask

  task automatic wait_rx(input int n);
    logic [31:0] d;
    logic [1:0]  r;
    do axil_read(axil_rx_count_c, d, r); while (d < n);
  endtask

  task automatic wait_credits(input int n);
    logic [31:0] d;
    logic [1:0]  r;
    do axil_read(axil_credits_c, d, r); while (d != n);
  endtask

  task automatic pop_check(input logic [15:0] addr, input logic [7:0] id);
    logic [31:0] d;
    logic [1:0]  r;
    axil_read(axil_rx_id_c, d, r);
    check_val("rx_id", d, {24'h0, id});
    axil_read(axil_rx_data_c, d, r);
    check_val("rx_data", d, ref_load(addr));
    check_val("rx_data rresp", {30'h0, r}, {30'h0, resp_okay_c});
  endtask

  task automatic host_load(input logic [15:0] addr, input logic [7:0] id);
    send_packet(op_load, addr, {24'h0, id});
    wait_rx(1);
    pop_check(addr, id);
  endtask

  // --------------------
  // DMA read compare
  // --------------------
  always @(posedge clk) begin
    logic [31:0] exp;
    if (arst_n) begin
      assert (dma_rvalid === dma_rd_pend) else begin
        $display("FAILED at %0t ns: dma_rvalid_o not one cycle after the read grant", $time);
        n_errors++;
      end
      if (dma_rvalid) begin
        if (dma_exp_q.size() == 0) begin
          $display("error: DMA read data came back with no DMA read outstanding");
          n_errors++;
        end else begin
          exp = dma_exp_q.pop_front();
          check_val("dma_rdata_o", dma_rdata, exp);
        end
      end
    end
    dma_rd_pend = arst_n & dma_ready & ~dma_we;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_lp) begin
      $display("timeout: the run was still busy after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int          e0;
    logic [31:0] d;
    logic [1:0]  r;
    arst_n    = 1'b0;
    awaddr    = '0;
    wdata     = '0;
    wstrb     = 4'hf;
    awvalid   = 1'b0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    dma_v     = 1'b0;
    dma_we    = 1'b0;
    dma_addr  = '0;
    dma_wdata = '0;
    // host owns the low half, DMA the high half
    for (int i = 0; i < rand_ops_lp; i++) begin
      h_addr[i] = 16'($random(seed) & 32'h1ff);
      h_data[i] = $random(seed);
      h_pick[i] = int'($unsigned($random(seed)) % (i + 1));
      d_addr[i] = addr_w_lp'(32'h200 | ($random(seed) & 32'h1ff));
      d_data[i] = $random(seed);
      d_pick[i] = int'($unsigned($random(seed)) % (i + 1));
    end
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    e0 = n_errors;
    host_store(16'h0010, $random(seed));
    host_load(16'h0010, 8'h5a);
    end_test("host store then load", e0);

    e0 = n_errors;
    dma_access(1'b1, 10'd20, $random(seed));
    host_load(16'd20, 8'h21);
    host_store(16'd30, $random(seed));
    wait_credits(credits_lp);
    dma_access(1'b0, 10'd30, '0);
    repeat (2) @(posedge clk);
    #1;
    end_test("DMA and host sharing", e0);

    e0 = n_errors;
    fork
      for (int i = 0; i < rand_ops_lp; i++) begin
        host_store(h_addr[i], h_data[i]);
        host_load(h_addr[h_pick[i]], 8'(8'h40 + i));
      end
      for (int i = 0; i < rand_ops_lp; i++) begin
        dma_access(1'b1, d_addr[i], d_data[i]);
        repeat (d_pick[i] % 4) begin
          @(posedge clk);
          #1;
        end
        dma_access(1'b0, d_addr[d_pick[i]], '0);
      end
    join
    repeat (2) @(posedge clk);
    #1;
    end_test("random mixed traffic", e0);

    e0 = n_errors;
    axil_read(axil_credits_c, d, r);
    check_val("credits at start", d, credits_lp);
    for (int i = 0; i < credits_lp; i++) begin
      send_packet(op_load, h_addr[i], 32'(i + 1));
    end
    wait_rx(credits_lp);
    axil_read(axil_credits_c, d, r);
    check_val("credits used up", d, 0);
    send_packet(op_load, h_addr[0], 32'h77);
    // extra packet must stay in the transmit FIFO
    repeat (3) begin
      axil_read(axil_rx_count_c, d, r);
      check_val("rx_count while stalled", d, credits_lp);
    end
    for (int i = 0; i < credits_lp; i++) begin
      pop_check(h_addr[i], 8'(i + 1));
    end
    wait_rx(1);
    pop_check(h_addr[0], 8'h77);
    axil_read(axil_credits_c, d, r);
    check_val("credits returned", d, credits_lp);
    end_test("out-credits", e0);

    e0 = n_errors;
    axil_write(12'h100, 32'h1234, r);
    check_val("unmapped bresp", {30'h0, r}, {30'h0, resp_slverr_c});
    axil_read(12'h100, d, r);
    check_val("unmapped rdata", d, 0);
    check_val("unmapped rresp", {30'h0, r}, {30'h0, resp_slverr_c});
    axil_read(axil_rx_data_c, d, r);
    check_val("empty pop rdata", d, 0);
    check_val("empty pop rresp", {30'h0, r}, {30'h0, resp_slverr_c});
    // leave a write, a read and a DMA read in flight, then reset
    awaddr  = {20'h0, axil_tx_lo_c};
    wdata   = '0;
    araddr  = {20'h0, axil_credits_c};
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    dma_we  = 1'b0;
    dma_v   = 1'b1;
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    dma_v   = 1'b0;
    arst_n  = 1'b0;
    #1;
    check_val("dma_rvalid in reset", {31'h0, dma_rvalid}, 0);
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_val("bvalid after reset", {31'h0, bvalid}, 0);
    check_val("rvalid after reset", {31'h0, rvalid}, 0);
    check_val("dma_ready after reset", {31'h0, dma_ready}, 0);
    axil_read(axil_credits_c, d, r);
    check_val("credits after reset", d, credits_lp);
    end_test("errors and reset", e0);

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, n_checks, n_errors, u_dut.arbiter.u_arb_assert.fail_cnt);
    if (n_errors == 0 && u_dut.arbiter.u_arb_assert.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb/hb_mc_assert.sv
// --------------------
// arbiter checks
// one grant at a time, grants only to requesters
// one rvalid per read grant
// --------------------
`timescale 1ns/1ps

module hb_mc_assert (
  input  logic clk_i
  ,input  logic arst_n_i
  ,input  logic ep_req_i
  ,input  logic ep_we_i
  ,input  logic ep_gnt_i
  ,input  logic ep_rvalid_i
  ,input  logic dma_req_i
  ,input  logic dma_we_i
  ,input  logic dma_gnt_i
  ,input  logic dma_rvalid_i
);

  int fail_cnt = 0;

  a_one_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ep_gnt_i && dma_gnt_i))
    else begin
      $error("endpoint and DMA granted in the same cycle");
      fail_cnt++;
    end

  a_gnt_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!ep_gnt_i || ep_req_i) && (!dma_gnt_i || dma_req_i))
    else begin
      $error("grant given to a master without a request");
      fail_cnt++;
    end

  // rvalid exactly when the previous cycle held a read grant
  a_rd_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ep_rvalid_i == $past(ep_gnt_i && !ep_we_i))
    && (dma_rvalid_i == $past(dma_gnt_i && !dma_we_i)))
    else begin
      $error("read valid does not follow a read grant by one cycle");
      fail_cnt++;
    end

endmodule

bind mem_arbiter hb_mc_assert u_arb_assert (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .ep_req_i    (ep_req_i),
  .ep_we_i     (ep_we_i),
  .ep_gnt_i    (ep_gnt_o),
  .ep_rvalid_i (ep_rvalid_o),
  .dma_req_i   (dma_req_i),
  .dma_we_i    (dma_we_i),
  .dma_gnt_i   (dma_gnt_o),
  .dma_rvalid_i(dma_rvalid_o)
);

// File: src/hb_mc_top.sv
// --------------------
// top of the host bridge
// AXI-lite link, endpoint, arbiter
// and the shared memory bank
// --------------------
`timescale 1ns/1ps

module hb_mc_top
  import hb_mc_pkg::*;
#(
  parameter int mem_addr_width_p   = 10
  ,parameter int fifo_depth_p      = 4
  ,parameter int max_out_credits_p = 4
) (
  input  logic                        clk_i
  ,input  logic                        arst_n_i
  // AXI-lite slave
  ,input  logic [31:0]                 s_axil_awaddr_i
  ,input  logic                        s_axil_awvalid_i
  ,output logic                        s_axil_awready_o
  ,input  logic [31:0]                 s_axil_wdata_i
  ,input  logic [3:0]                  s_axil_wstrb_i
  ,input  logic                        s_axil_wvalid_i
  ,output logic                        s_axil_wready_o
  ,output logic [1:0]                  s_axil_bresp_o
  ,output logic                        s_axil_bvalid_o
  ,input  logic                        s_axil_bready_i
  ,input  logic [31:0]                 s_axil_araddr_i
  ,input  logic                        s_axil_arvalid_i
  ,output logic                        s_axil_arready_o
  ,output logic [31:0]                 s_axil_rdata_o
  ,output logic [1:0]                  s_axil_rresp_o
  ,output logic                        s_axil_rvalid_o
  ,input  logic                        s_axil_rready_i
  // host DMA port
  ,input  logic                        dma_v_i
  ,input  logic                        dma_we_i
  ,input  logic [mem_addr_width_p-1:0] dma_addr_i
  ,input  logic [data_width_c-1:0]     dma_wdata_i
  ,output logic                        dma_ready_o
  ,output logic [data_width_c-1:0]     dma_rdata_o
  ,output logic                        dma_rvalid_o
);

  localparam int credit_width_lp = $clog2(max_out_credits_p+1);

  logic                        tx_v, tx_pop, rx_push, rx_pop;
  mc_packet_u                  tx_packet;
  logic [7:0]                  rx_id;
  logic [data_width_c-1:0]     rx_data;
  logic [credit_width_lp-1:0]  credits;

  logic                        ep_req, ep_we, ep_gnt, ep_rvalid;
  logic [mem_addr_width_p-1:0] ep_addr;
  logic [data_width_c-1:0]     ep_wdata, ep_rdata;

  logic                        mem_en, mem_we;
  logic [mem_addr_width_p-1:0] mem_addr;
  logic [data_width_c-1:0]     mem_wdata, mem_rdata;

  mcl_axil_fifos #(
    .fifo_depth_p     (fifo_depth_p),
    .max_out_credits_p(max_out_credits_p)
  ) axil_fifos (
    .clk_i, .arst_n_i,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .tx_pop_i   (tx_pop),
    .rx_push_i  (rx_push),
    .rx_id_i    (rx_id),
    .rx_data_i  (rx_data),
    .credits_i  (credits),
    .tx_v_o     (tx_v),
    .tx_packet_o(tx_packet),
    .rx_pop_o   (rx_pop)
  );

  mc_endpoint #(
    .mem_addr_width_p (mem_addr_width_p),
    .max_out_credits_p(max_out_credits_p)
  ) endpoint (
    .clk_i, .arst_n_i,
    .tx_v_i     (tx_v),
    .tx_packet_i(tx_packet),
    .rx_pop_i   (rx_pop),
    .gnt_i      (ep_gnt),
    .rdata_i    (ep_rdata),
    .rvalid_i   (ep_rvalid),
    .tx_pop_o   (tx_pop),
    .rx_push_o  (rx_push),
    .rx_id_o    (rx_id),
    .rx_data_o  (rx_data),
    .credits_o  (credits),
    .req_o      (ep_req),
    .we_o       (ep_we),
    .addr_o     (ep_addr),
    .wdata_o    (ep_wdata)
  );

  mem_arbiter #(
    .mem_addr_width_p(mem_addr_width_p)
  ) arbiter (
    .clk_i, .arst_n_i,
    .ep_req_i    (ep_req),
    .ep_we_i     (ep_we),
    .ep_addr_i   (ep_addr),
    .ep_wdata_i  (ep_wdata),
    .dma_req_i   (dma_v_i),
    .dma_we_i    (dma_we_i),
    .dma_addr_i  (dma_addr_i),
    .dma_wdata_i (dma_wdata_i),
    .mem_rdata_i (mem_rdata),
    .ep_gnt_o    (ep_gnt),
    .dma_gnt_o   (dma_ready_o),
    .ep_rdata_o  (ep_rdata),
    .ep_rvalid_o (ep_rvalid),
    .dma_rdata_o (dma_rdata_o),
    .dma_rvalid_o(dma_rvalid_o),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata)
  );

  dram_bank #(
    .mem_addr_width_p(mem_addr_width_p)
  ) bank (
    .clk_i,
    .mem_en_i   (mem_en),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wdata_i(mem_wdata),
    .mem_rdata_o(mem_rdata)
  );

endmodule

// File: src/dram_bank.sv
// --------------------
// single-port word memory
// registered read data
// --------------------
`timescale 1ns/1ps

module dram_bank
  import hb_mc_pkg::*;
#(
  parameter int mem_addr_width_p = 10
) (
  input  logic                        clk_i
  ,input  logic                        mem_en_i
  ,input  logic                        mem_we_i
  ,input  logic [mem_addr_width_p-1:0] mem_addr_i
  ,input  logic [data_width_c-1:0]     mem_wdata_i
  ,output logic [data_width_c-1:0]     mem_rdata_o
);

  localparam int els_lp = 2 ** mem_addr_width_p;

  logic [data_width_c-1:0] mem [els_lp];
  logic [data_width_c-1:0] rdata_r;

  always_ff @(posedge clk_i) begin
    if (mem_en_i) begin
      if (mem_we_i) begin
        mem[mem_addr_i] <= mem_wdata_i;
      end else begin
        rdata_r <= mem[mem_addr_i];
      end
    end
  end

  assign mem_rdata_o = rdata_r;

endmodule

// File: src/mem_arbiter.sv
// --------------------
// round-robin arbiter
// endpoint and DMA onto one memory port
// --------------------
`timescale 1ns/1ps

module mem_arbiter
  import hb_mc_pkg::*;
#(
  parameter int mem_addr_width_p = 10
) (
  input  logic                        clk_i
  ,input  logic                        arst_n_i
  ,input  logic                        ep_req_i
  ,input  logic                        ep_we_i
  ,input  logic [mem_addr_width_p-1:0] ep_addr_i
  ,input  logic [data_width_c-1:0]     ep_wdata_i
  ,input  logic                        dma_req_i
  ,input  logic                        dma_we_i
  ,input  logic [mem_addr_width_p-1:0] dma_addr_i
  ,input  logic [data_width_c-1:0]     dma_wdata_i
  ,input  logic [data_width_c-1:0]     mem_rdata_i
  ,output logic                        ep_gnt_o
  ,output logic                        dma_gnt_o
  ,output logic [data_width_c-1:0]     ep_rdata_o
  ,output logic                        ep_rvalid_o
  ,output logic [data_width_c-1:0]     dma_rdata_o
  ,output logic                        dma_rvalid_o
  ,output logic                        mem_en_o
  ,output logic                        mem_we_o
  ,output logic [mem_addr_width_p-1:0] mem_addr_o
  ,output logic [data_width_c-1:0]     mem_wdata_o
);

  // last grant went to the endpoint, cleared so it wins first
  logic last_ep_r;
  logic ep_rd_r, dma_rd_r;

  assign ep_gnt_o  = ep_req_i & (~dma_req_i | ~last_ep_r);
  assign dma_gnt_o = dma_req_i & ~ep_gnt_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_ep_r <= 1'b0;
      ep_rd_r   <= 1'b0;
      dma_rd_r  <= 1'b0;
    end else begin
      if (ep_gnt_o) begin
        last_ep_r <= 1'b1;
      end else if (dma_gnt_o) begin
        last_ep_r <= 1'b0;
      end
      // owner of the word the bank returns next cycle
      ep_rd_r  <= ep_gnt_o & ~ep_we_i;
      dma_rd_r <= dma_gnt_o & ~dma_we_i;
    end
  end

  assign mem_en_o    = ep_gnt_o | dma_gnt_o;
  assign mem_we_o    = ep_gnt_o ? ep_we_i : dma_we_i;
  assign mem_addr_o  = ep_gnt_o ? ep_addr_i : dma_addr_i;
  assign mem_wdata_o = ep_gnt_o ? ep_wdata_i : dma_wdata_i;

  assign ep_rvalid_o  = ep_rd_r;
  assign dma_rvalid_o = dma_rd_r;
  assign ep_rdata_o   = ep_rd_r ? mem_rdata_i : '0;
  assign dma_rdata_o  = dma_rd_r ? mem_rdata_i : '0;

endmodule

// File: src/mc_endpoint.sv
// --------------------
// packet endpoint
// decode, memory request, load response
// and out-credit counter
// --------------------
`timescale 1ns/1ps

module mc_endpoint
  import hb_mc_pkg::*;
#(
  parameter int mem_addr_width_p   = 10
  ,parameter int max_out_credits_p = 4
  ,localparam int credit_width_lp  = $clog2(max_out_credits_p+1)
) (
  input  logic                        clk_i
  ,input  logic                        arst_n_i
  ,input  logic                        tx_v_i
  ,input  mc_packet_u                  tx_packet_i
  ,input  logic                        rx_pop_i
  ,input  logic                        gnt_i
  ,input  logic [data_width_c-1:0]     rdata_i
  ,input  logic                        rvalid_i
  ,output logic                        tx_pop_o
  ,output logic                        rx_push_o
  ,output logic [7:0]                  rx_id_o
  ,output logic [data_width_c-1:0]     rx_data_o
  ,output logic [credit_width_lp-1:0]  credits_o
  ,output logic                        req_o
  ,output logic                        we_o
  ,output logic [mem_addr_width_p-1:0] addr_o
  ,output logic [data_width_c-1:0]     wdata_o
);

  logic                        busy_r, we_r;
  logic [mem_addr_width_p-1:0] addr_r;
  logic [data_width_c-1:0]     wdata_r;
  logic [7:0]                  id_r;
  logic [credit_width_lp-1:0]  credits_r;
  logic                        is_store, is_load, credit_take, credit_ret_st;

  assign is_store = (tx_packet_i.store.op == op_store);
  assign is_load  = (tx_packet_i.load.op == op_load);

  // idle with a credit left takes the head packet
  assign tx_pop_o = tx_v_i & ~busy_r & (credits_r != '0);

  // ignored opcodes give their credit straight back
  assign credit_take   = tx_pop_o & (is_store | is_load);
  assign credit_ret_st = gnt_i & we_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r    <= 1'b0;
      credits_r <= credit_width_lp'(max_out_credits_p);
    end else begin
      if (tx_pop_o) begin
        busy_r <= is_store | is_load;
      end else if (gnt_i) begin
        busy_r <= 1'b0;
      end
      credits_r <= credits_r - credit_width_lp'(credit_take)
                   + credit_width_lp'(credit_ret_st) + credit_width_lp'(rx_pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_pop_o) begin
      we_r    <= is_store;
      wdata_r <= tx_packet_i.store.data;
      addr_r  <= is_load ? tx_packet_i.load.addr[mem_addr_width_p-1:0]
                         : tx_packet_i.store.addr[mem_addr_width_p-1:0];
    end
    // id stays until the next load, so it pairs with the returning word
    if (tx_pop_o && is_load) begin
      id_r <= tx_packet_i.load.id;
    end
  end

  assign req_o     = busy_r;
  assign we_o      = we_r;
  assign addr_o    = addr_r;
  assign wdata_o   = wdata_r;
  assign credits_o = credits_r;

  // load data lands one cycle after the grant
  assign rx_push_o = rvalid_i;
  assign rx_data_o = rdata_i;
  assign rx_id_o   = id_r;

endmodule

// File: src/mcl_axil_fifos.sv
// --------------------
// AXI-lite slave to packet FIFOs
// transmit and receive circular FIFOs
// and the register decode
// --------------------
`timescale 1ns/1ps

module mcl_axil_fifos
  import hb_mc_pkg::*;
#(
  parameter int fifo_depth_p       = 4
  ,parameter int max_out_credits_p = 4
  ,localparam int credit_width_lp  = $clog2(max_out_credits_p+1)
) (
  input  logic                       clk_i
  ,input  logic                       arst_n_i
  ,input  logic [31:0]                s_axil_awaddr_i
  ,input  logic                       s_axil_awvalid_i
  ,output logic                       s_axil_awready_o
  ,input  logic [31:0]                s_axil_wdata_i
  ,input  logic [3:0]                 s_axil_wstrb_i
  ,input  logic                       s_axil_wvalid_i
  ,output logic                       s_axil_wready_o
  ,output logic [1:0]                 s_axil_bresp_o
  ,output logic                       s_axil_bvalid_o
  ,input  logic                       s_axil_bready_i
  ,input  logic [31:0]                s_axil_araddr_i
  ,input  logic                       s_axil_arvalid_i
  ,output logic                       s_axil_arready_o
  ,output logic [31:0]                s_axil_rdata_o
  ,output logic [1:0]                 s_axil_rresp_o
  ,output logic                       s_axil_rvalid_o
  ,input  logic                       s_axil_rready_i
  ,input  logic                       tx_pop_i
  ,input  logic                       rx_push_i
  ,input  logic [7:0]                 rx_id_i
  ,input  logic [data_width_c-1:0]    rx_data_i
  ,input  logic [credit_width_lp-1:0] credits_i
  ,output logic                       tx_v_o
  ,output mc_packet_u                 tx_packet_o
  ,output logic                       rx_pop_o
);

  localparam int ptr_width_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(fifo_depth_p+1);

  // circular pointer step, depth need not be a power of two
  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(fifo_depth_p-1)) ? '0 : ptr + 1'b1;
  endfunction

  mc_packet_u              tx_mem [fifo_depth_p];
  logic [data_width_c-1:0] rx_data_mem [fifo_depth_p];
  logic [7:0]              rx_id_mem [fifo_depth_p];
  logic [ptr_width_lp-1:0] tx_wr_ptr_r, tx_rd_ptr_r, rx_wr_ptr_r, rx_rd_ptr_r;
  logic [cnt_width_lp-1:0] tx_count_r, rx_count_r;

  logic                    wr_accept, wr_lo, wr_hi, tx_full, tx_push;
  logic [data_width_c-1:0] strb_mask, lo_r;
  logic                    bvalid_r;
  logic [1:0]              bresp_r;

  logic                    rd_accept, rx_empty, rvalid_r;
  logic [data_width_c-1:0] rd_data, rdata_r;
  logic [1:0]              rd_resp, rresp_r;

  // --------------------
  // write channel
  // --------------------
  assign wr_accept        = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_r;
  assign s_axil_awready_o = wr_accept;
  assign s_axil_wready_o  = wr_accept;
  assign wr_lo            = (s_axil_awaddr_i[11:0] == axil_tx_lo_c);
  assign wr_hi            = (s_axil_awaddr_i[11:0] == axil_tx_hi_c);
  assign tx_full          = (tx_count_r == cnt_width_lp'(fifo_depth_p));
  // full FIFO drops the packet
  assign tx_push          = wr_accept & wr_hi & ~tx_full;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      strb_mask[8*i +: 8] = {8{s_axil_wstrb_i[i]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept && wr_lo) begin
      lo_r <= (lo_r & ~strb_mask) | (s_axil_wdata_i & strb_mask);
    end
    if (tx_push) begin
      tx_mem[tx_wr_ptr_r] <= {s_axil_wdata_i & strb_mask, lo_r};
    end
    if (rx_push_i) begin
      rx_data_mem[rx_wr_ptr_r] <= rx_data_i;
      rx_id_mem[rx_wr_ptr_r]   <= rx_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_r <= 1'b0;
      bresp_r  <= resp_okay_c;
    end else if (wr_accept) begin
      bvalid_r <= 1'b1;
      bresp_r  <= (wr_lo || tx_push) ? resp_okay_c : resp_slverr_c;
    end else if (s_axil_bready_i) begin
      bvalid_r <= 1'b0;
    end
  end

  assign s_axil_bvalid_o = bvalid_r;
  assign s_axil_bresp_o  = bresp_r;

  // --------------------
  // FIFO pointers
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_wr_ptr_r <= '0;
      tx_rd_ptr_r <= '0;
      tx_count_r  <= '0;
      rx_wr_ptr_r <= '0;
      rx_rd_ptr_r <= '0;
      rx_count_r  <= '0;
    end else begin
      if (tx_push) begin
        tx_wr_ptr_r <= ptr_inc(tx_wr_ptr_r);
      end
      if (tx_pop_i) begin
        tx_rd_ptr_r <= ptr_inc(tx_rd_ptr_r);
      end
      if (rx_push_i) begin
        rx_wr_ptr_r <= ptr_inc(rx_wr_ptr_r);
      end
      if (rx_pop_o) begin
        rx_rd_ptr_r <= ptr_inc(rx_rd_ptr_r);
      end
      tx_count_r <= tx_count_r + cnt_width_lp'(tx_push) - cnt_width_lp'(tx_pop_i);
      rx_count_r <= rx_count_r + cnt_width_lp'(rx_push_i) - cnt_width_lp'(rx_pop_o);
    end
  end

  assign tx_v_o      = (tx_count_r != '0);
  assign tx_packet_o = tx_mem[tx_rd_ptr_r];

  // --------------------
  // read channel
  // --------------------
  assign rd_accept        = s_axil_arvalid_i & ~rvalid_r;
  assign s_axil_arready_o = ~rvalid_r;
  assign rx_empty         = (rx_count_r == '0);
  assign rx_pop_o         = rd_accept & ~rx_empty
                            & (s_axil_araddr_i[11:0] == axil_rx_data_c);

  always_comb begin
    rd_data = '0;
    rd_resp = resp_okay_c;
    case (s_axil_araddr_i[11:0])
      axil_rx_data_c: begin
        if (rx_empty) begin
          rd_resp = resp_slverr_c;
        end else begin
          rd_data = rx_data_mem[rx_rd_ptr_r];
        end
      end
      axil_rx_id_c:    rd_data = data_width_c'(rx_id_mem[rx_rd_ptr_r]);
      axil_rx_count_c: rd_data = data_width_c'(rx_count_r);
      axil_credits_c:  rd_data = data_width_c'(credits_i);
      default:         rd_resp = resp_slverr_c;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_r <= 1'b0;
      rdata_r  <= '0;
      rresp_r  <= resp_okay_c;
    end else if (rd_accept) begin
      rvalid_r <= 1'b1;
      rdata_r  <= rd_data;
      rresp_r  <= rd_resp;
    end else if (s_axil_rready_i) begin
      rvalid_r <= 1'b0;
    end
  end

  assign s_axil_rvalid_o = rvalid_r;
  assign s_axil_rdata_o  = rdata_r;
  assign s_axil_rresp_o  = rresp_r;

endmodule

// File: src/hb_mc_pkg.sv
// --------------------
// shared definitions of the host bridge
// packet word, opcodes, register map
// and AXI response codes
// --------------------

package hb_mc_pkg;

  localparam int data_width_c = 32;

  // only these two codes do anything
  typedef enum logic [1:0] {
    op_store = 2'b01
    ,op_load = 2'b10
  } mc_op_e;

  // one 64-bit packet, seen as a store or as a load
  typedef union packed {
    struct packed {
      mc_op_e      op;
      logic [13:0] rsvd;
      logic [15:0] addr;
      logic [31:0] data;
    } store;
    struct packed {
      mc_op_e      op;
      logic [13:0] rsvd;
      logic [15:0] addr;
      logic [23:0] rsvd_lo;
      logic [7:0]  id;
    } load;
  } mc_packet_u;

  // --------------------
  // register map
  // --------------------
  localparam logic [11:0] axil_tx_lo_c    = 12'h000;
  localparam logic [11:0] axil_tx_hi_c    = 12'h004;
  localparam logic [11:0] axil_rx_data_c  = 12'h010;
  localparam logic [11:0] axil_rx_count_c = 12'h014;
  localparam logic [11:0] axil_credits_c  = 12'h018;
  localparam logic [11:0] axil_rx_id_c    = 12'h01C;

  localparam logic [1:0] resp_okay_c   = 2'd0;
  localparam logic [1:0] resp_slverr_c = 2'd2;

endpackage
